// File: logic/camera_pkg.sv
package camera_pkg;

    // CSI-2 data type codes, six bits
    localparam logic [5:0] DT_FRAME_START  = 6'h00;
    localparam logic [5:0] DT_FRAME_END    = 6'h01;
    localparam logic [5:0] DT_RAW10        = 6'h2B;
    localparam logic [5:0] LONG_PACKET_MIN = 6'h10;  // codes from here up are long packets

    // RAW10 packs four pixels into five bytes
    localparam int RAW10_GROUP_BYTES = 5;
    localparam int PIXELS_PER_GROUP  = 4;

    typedef logic [9:0] pixel_t;

    // one 32-bit word per RAW10 group
    localparam int FB_ADDR_W = 8;
    localparam int FB_WORDS  = 1 << FB_ADDR_W;  // 256 words

endpackage

// File: logic/camera_if.sv
`timescale 1ns/1ps

// RAW10 payload bytes and frame events from the packet decoder
interface payload_if ();
    logic       valid;        // one payload byte
    logic [7:0] data;
    logic       frame_start;  // single-cycle pulse
    logic       frame_end;    // single-cycle pulse

    modport source (
        output valid,
        output data,
        output frame_start,
        output frame_end
    );

    modport sink (
        input valid,
        input data,
        input frame_start,
        input frame_end
    );
endinterface

// four unpacked pixels per beat, pixel 0 in the low slot
interface pixel_group_if import camera_pkg::*;
();
    logic                          valid;
    pixel_t [PIXELS_PER_GROUP-1:0] pixels;
    logic                          frame_start;
    logic                          frame_end;

    modport source (
        output valid,
        output pixels,
        output frame_start,
        output frame_end
    );

    modport sink (
        input valid,
        input pixels,
        input frame_start,
        input frame_end
    );
endinterface

// File: logic/csi2_packet_decode.sv
`timescale 1ns/1ps

module csi2_packet_decode import camera_pkg::*; (
    input  logic       byte_clk_hs,
    input  logic       reset_n_clock_96MHz,
    input  logic       byte_valid_i,
    input  logic [7:0] byte_i,
    input  logic       sot_i,
    payload_if.source  payload_o,
    output logic [7:0] ecc_error_count_o
);

    typedef enum logic [1:0] {
        ST_HEADER,
        ST_PAYLOAD,
        ST_CRC,
        ST_DISCARD
    } state_t;

    state_t      state;
    logic [1:0]  byte_index;     // header byte, then crc byte position
    logic [15:0] bytes_left;     // payload bytes still to come
    logic        forward_raw10;  // current long packet is pixel data
    logic [7:0]  header_id;
    logic [7:0]  header_wc_lo;
    logic [7:0]  header_wc_hi;
    logic [5:0]  header_dt;
    logic [15:0] header_wc;
    logic        ecc_ok;

    // CSI-2 header Hamming code, one parity mask per ECC bit
    function automatic logic [5:0] csi2_ecc(input logic [23:0] d);
        logic [5:0] p;
        p[0] = ^(d & 24'hF1_2CB7);
        p[1] = ^(d & 24'hF2_555B);
        p[2] = ^(d & 24'h74_9A6D);
        p[3] = ^(d & 24'hB8_E38E);
        p[4] = ^(d & 24'hDF_03F0);
        p[5] = ^(d & 24'hEF_FC00);
        return p;
    endfunction

    assign header_dt = header_id[5:0];  // virtual channel ignored
    assign header_wc = {header_wc_hi, header_wc_lo};
    assign ecc_ok    = byte_i == {2'b00, csi2_ecc({header_wc_hi, header_wc_lo, header_id})};

    always_ff @(posedge byte_clk_hs or negedge reset_n_clock_96MHz) begin
        if (!reset_n_clock_96MHz) begin
            state                 <= ST_DISCARD;  // wait for the first sot
            byte_index            <= 2'd0;
            bytes_left            <= 16'd0;
            forward_raw10         <= 1'b0;
            ecc_error_count_o     <= 8'd0;
            payload_o.valid       <= 1'b0;
            payload_o.frame_start <= 1'b0;
            payload_o.frame_end   <= 1'b0;
        end else begin
            payload_o.valid       <= 1'b0;
            payload_o.frame_start <= 1'b0;
            payload_o.frame_end   <= 1'b0;
            if (byte_valid_i && sot_i) begin
                state      <= ST_HEADER;  // sot byte is the data identifier
                byte_index <= 2'd1;
            end else if (byte_valid_i) begin
                case (state)
                    ST_HEADER: begin
                        byte_index <= byte_index + 2'd1;
                        if (byte_index == 2'd3) begin
                            if (!ecc_ok) begin
                                state <= ST_DISCARD;  // drop until next sot
                                if (ecc_error_count_o != 8'hFF) begin
                                    ecc_error_count_o <= ecc_error_count_o + 8'd1;
                                end
                            end else if (header_dt < LONG_PACKET_MIN) begin
                                state                 <= ST_DISCARD;
                                payload_o.frame_start <= header_dt == DT_FRAME_START;
                                payload_o.frame_end   <= header_dt == DT_FRAME_END;
                            end else begin
                                bytes_left    <= header_wc;
                                forward_raw10 <= header_dt == DT_RAW10;
                                byte_index    <= 2'd0;
                                state         <= (header_wc == 16'd0) ? ST_CRC : ST_PAYLOAD;
                            end
                        end
                    end
                    ST_PAYLOAD: begin
                        payload_o.valid <= forward_raw10;  // other types skipped silently
                        bytes_left      <= bytes_left - 16'd1;
                        if (bytes_left == 16'd1) begin
                            state <= ST_CRC;
                        end
                    end
                    ST_CRC: begin
                        byte_index <= byte_index + 2'd1;  // two crc bytes, not checked
                        if (byte_index == 2'd1) begin
                            state <= ST_DISCARD;
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge byte_clk_hs) begin
        if (byte_valid_i) begin
            if (sot_i) begin
                header_id <= byte_i;
            end else if (state == ST_HEADER && byte_index == 2'd1) begin
                header_wc_lo <= byte_i;
            end else if (state == ST_HEADER && byte_index == 2'd2) begin
                header_wc_hi <= byte_i;
            end
            payload_o.data <= byte_i;  // qualified by payload_o.valid
        end
    end

endmodule

// File: logic/raw10_unpack.sv
`timescale 1ns/1ps

module raw10_unpack import camera_pkg::*; (
    input  logic          byte_clk_hs,
    input  logic          reset_n_clock_96MHz,
    payload_if.sink       payload_i,
    pixel_group_if.source group_o
);

    logic [7:0] group_bytes [RAW10_GROUP_BYTES-1];  // upper bits of pixels 0..3
    logic [2:0] byte_count;
    logic       group_done;

    // fifth byte carries the two low bits of every pixel
    assign group_done = payload_i.valid && byte_count == 3'(RAW10_GROUP_BYTES - 1);

    always_ff @(posedge byte_clk_hs or negedge reset_n_clock_96MHz) begin
        if (!reset_n_clock_96MHz) begin
            byte_count          <= 3'd0;
            group_o.valid       <= 1'b0;
            group_o.frame_start <= 1'b0;
            group_o.frame_end   <= 1'b0;
        end else begin
            group_o.valid       <= group_done;
            group_o.frame_start <= payload_i.frame_start;  // same delay as data
            group_o.frame_end   <= payload_i.frame_end;
            if (payload_i.frame_start || group_done) begin
                byte_count <= 3'd0;  // no carry-over from a cut group
            end else if (payload_i.valid) begin
                byte_count <= byte_count + 3'd1;
            end
        end
    end

    always_ff @(posedge byte_clk_hs) begin
        if (payload_i.valid && !group_done) begin
            group_bytes[byte_count[1:0]] <= payload_i.data;
        end
        if (group_done) begin
            for (int k = 0; k < PIXELS_PER_GROUP; k++) begin
                group_o.pixels[k] <= {group_bytes[k], payload_i.data[2*k +: 2]};
            end
        end
    end

endmodule

// File: logic/frame_buffer.sv
`timescale 1ns/1ps

module frame_buffer import camera_pkg::*; (
    input  logic                 byte_clk_hs,
    input  logic                 reset_n_clock_96MHz,
    pixel_group_if.sink          group_i,
    input  logic                 camera_ram_read_enable_i,
    input  logic [FB_ADDR_W-1:0] camera_ram_read_address_i,
    output logic [31:0]          camera_ram_read_data_o,
    output logic [7:0]           frame_count_o,
    output logic                 frame_active_o
);

    logic [31:0]          buffer_ram [FB_WORDS];
    logic [FB_ADDR_W:0]   write_count;    // stops at FB_WORDS
    logic [FB_ADDR_W-1:0] write_address;
    logic                 write_enable;
    logic [31:0]          write_word;

    // top 8 bits of each pixel, pixel 0 in the low byte
    always_comb begin
        for (int k = 0; k < PIXELS_PER_GROUP; k++) begin
            write_word[8*k +: 8] = group_i.pixels[k][9:2];
        end
    end

    assign write_address = write_count[FB_ADDR_W-1:0];
    assign write_enable  = group_i.valid && write_count < (FB_ADDR_W + 1)'(FB_WORDS);

    always_ff @(posedge byte_clk_hs or negedge reset_n_clock_96MHz) begin
        if (!reset_n_clock_96MHz) begin
            write_count    <= '0;
            frame_active_o <= 1'b0;
            frame_count_o  <= 8'd0;
        end else begin
            if (group_i.frame_start) begin
                write_count    <= '0;
                frame_active_o <= 1'b1;
            end else if (write_enable) begin
                write_count <= write_count + 1'b1;  // extra groups dropped once full
            end
            if (group_i.frame_end) begin
                frame_active_o <= 1'b0;
                frame_count_o  <= frame_count_o + 8'd1;  // wraps
            end
        end
    end

    // simple dual-port RAM, read returns the old word on a collision
    always_ff @(posedge byte_clk_hs) begin
        if (write_enable) begin
            buffer_ram[write_address] <= write_word;
        end
        if (camera_ram_read_enable_i) begin
            camera_ram_read_data_o <= buffer_ram[camera_ram_read_address_i];
        end
    end

endmodule

// File: logic/camera.sv
`timescale 1ns/1ps

module camera import camera_pkg::*; (
    input  logic                 byte_clk_hs,
    input  logic                 reset_n_clock_96MHz,

    input  logic                 byte_valid_i,
    input  logic [7:0]           byte_i,
    input  logic                 sot_i,

    input  logic                 camera_ram_read_enable_i,
    input  logic [FB_ADDR_W-1:0] camera_ram_read_address_i,
    output logic [31:0]          camera_ram_read_data_o,

    output logic [7:0]           frame_count_o,
    output logic [7:0]           ecc_error_count_o,
    output logic                 frame_active_o
);

    payload_if     payload ();
    pixel_group_if pixel_group ();

    csi2_packet_decode packet_decode (
        .byte_clk_hs         (byte_clk_hs),
        .reset_n_clock_96MHz (reset_n_clock_96MHz),
        .byte_valid_i        (byte_valid_i),
        .byte_i              (byte_i),
        .sot_i               (sot_i),
        .payload_o           (payload.source),
        .ecc_error_count_o   (ecc_error_count_o)
    );

    raw10_unpack unpack (
        .byte_clk_hs         (byte_clk_hs),
        .reset_n_clock_96MHz (reset_n_clock_96MHz),
        .payload_i           (payload.sink),
        .group_o             (pixel_group.source)
    );

    frame_buffer buffer (
        .byte_clk_hs               (byte_clk_hs),
        .reset_n_clock_96MHz       (reset_n_clock_96MHz),
        .group_i                   (pixel_group.sink),
        .camera_ram_read_enable_i  (camera_ram_read_enable_i),
        .camera_ram_read_address_i (camera_ram_read_address_i),
        .camera_ram_read_data_o    (camera_ram_read_data_o),
        .frame_count_o             (frame_count_o),
        .frame_active_o            (frame_active_o)
    );

endmodule

// File: tests/camera_sva.sv
`timescale 1ns/1ps

module camera_sva import camera_pkg::*; (
    input logic                 byte_clk_hs,
    input logic                 reset_n_clock_96MHz,
    input logic                 payload_valid_i,
    input logic                 payload_start_i,
    input logic                 payload_end_i,
    input logic                 group_valid_i,
    input logic                 group_end_i,
    input logic [FB_ADDR_W:0]   write_count_i,
    input logic [7:0]           frame_count_i
);

    no_data_with_event: assert property (
        @(posedge byte_clk_hs) disable iff (!reset_n_clock_96MHz)
        !(payload_valid_i && (payload_start_i || payload_end_i))
    ) else $error("payload byte in the same cycle as a frame event");

    group_after_fifth_byte: assert property (
        @(posedge byte_clk_hs) disable iff (!reset_n_clock_96MHz)
        group_valid_i |-> $past(payload_valid_i)
    ) else $error("group valid without a payload byte one cycle before");

    // counter steps by one below FB_WORDS or clears on a frame start
    address_in_range: assert property (
        @(posedge byte_clk_hs) disable iff (!reset_n_clock_96MHz)
        $changed(write_count_i) |-> write_count_i == '0
            || (write_count_i == $past(write_count_i) + 1'b1
                && $past(write_count_i) < (FB_ADDR_W + 1)'(FB_WORDS))
    ) else $error("write address ran past the frame buffer");

    count_after_frame_end: assert property (
        @(posedge byte_clk_hs) disable iff (!reset_n_clock_96MHz)
        $changed(frame_count_i) |-> $past(group_end_i)
    ) else $error("frame count moved without a frame end");

endmodule

bind camera camera_sva assertions (
    .byte_clk_hs         (byte_clk_hs),
    .reset_n_clock_96MHz (reset_n_clock_96MHz),
    .payload_valid_i     (payload.valid),
    .payload_start_i     (payload.frame_start),
    .payload_end_i       (payload.frame_end),
    .group_valid_i       (pixel_group.valid),
    .group_end_i         (pixel_group.frame_end),
    .write_count_i       (buffer.write_count),
    .frame_count_i       (frame_count_o)
);

// File: tests/camera_tb.sv
`timescale 1ns/1ps

module camera_tb import camera_pkg::*; ();

    // ECC contribution of each header bit, bit 0 first
    localparam logic [5:0] ECC_COLUMN [24] = '{
        6'h07, 6'h0B, 6'h0D, 6'h0E, 6'h13, 6'h15, 6'h16, 6'h19,
        6'h1A, 6'h1C, 6'h23, 6'h25, 6'h26, 6'h29, 6'h2A, 6'h2C,
        6'h31, 6'h32, 6'h34, 6'h38, 6'h1F, 6'h2F, 6'h37, 6'h3B
    };

    logic                 byte_clk_hs;
    logic                 reset_n_clock_96MHz;
    logic                 byte_valid_i;
    logic [7:0]           byte_i;
    logic                 sot_i;
    logic                 camera_ram_read_enable_i;
    logic [FB_ADDR_W-1:0] camera_ram_read_address_i;
    logic [31:0]          camera_ram_read_data_o;
    logic [7:0]           frame_count_o;
    logic [7:0]           ecc_error_count_o;
    logic                 frame_active_o;

    logic [31:0] rng_state = 32'h3218_23f7;
    logic [31:0] model_mem [FB_WORDS];  // last word written per address
    int          model_count;           // words written in the current frame
    logic [7:0]  expected_frames;
    logic [7:0]  expected_ecc_errors;
    int          bytes_sent;
    int          cycles;
    logic        read_pending;
    logic [31:0] read_expect;
    logic        reads_on;

    camera uut (.*);

    always #20 byte_clk_hs = ~byte_clk_hs;

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    function automatic logic [7:0] header_ecc(input logic [23:0] d);
        logic [5:0] e;
        e = '0;
        for (int i = 0; i < 24; i++) begin
            if (d[i]) e ^= ECC_COLUMN[i];
        end
        return {2'b00, e};
    endfunction

    task automatic report_error(input string msg);
        $display("error at %0d ns: %s", $time, msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    // one lane cycle; also runs a background read of an already written word
    task automatic drive_cycle(input logic v, input logic [7:0] d, input logic s);
        int addr;
        @(posedge byte_clk_hs);
        #2;
        if (read_pending) begin
            assert (camera_ram_read_data_o == read_expect)
                else report_error($sformatf("read during writes got %h, expected %h",
                                            camera_ram_read_data_o, read_expect));
        end
        read_pending = 1'b0;
        byte_valid_i = v;
        byte_i       = d;
        sot_i        = s;
        camera_ram_read_enable_i = 1'b0;
        if (v) bytes_sent++;
        if (reads_on && model_count >= 2) begin
            addr = int'(next_random() % (model_count - 1));  // safely behind the writes
            camera_ram_read_enable_i  = 1'b1;
            camera_ram_read_address_i = FB_ADDR_W'(addr);
            read_expect  = model_mem[addr];
            read_pending = 1'b1;
        end
    endtask

    task automatic send_byte(input logic [7:0] b, input logic s);
        int gap;
        gap = int'(next_random() % 8);
        if (gap < 3) repeat (gap) drive_cycle(1'b0, 8'h00, 1'b0);  // idle lane
        drive_cycle(1'b1, b, s);
    endtask

    task automatic send_header(input logic [5:0] dt, input logic [15:0] wc, input bit corrupt);
        logic [31:0] r;
        logic [7:0]  id;
        logic [7:0]  ecc;
        r   = next_random();
        id  = {r[1:0], dt};  // any virtual channel
        ecc = header_ecc({wc, id});
        if (corrupt) ecc ^= 8'(1 << (r[15:8] % 6));
        send_byte(id, 1'b1);
        send_byte(wc[7:0], 1'b0);
        send_byte(wc[15:8], 1'b0);
        send_byte(ecc, 1'b0);
    endtask

    task automatic send_crc();
        logic [31:0] r;
        r = next_random();
        send_byte(r[7:0], 1'b0);
        send_byte(r[15:8], 1'b0);
    endtask

    task automatic send_line(input int groups, input bit corrupt);
        logic [31:0] r;
        logic [9:0]  px [4];
        logic [7:0]  low_bits;
        send_header(DT_RAW10, 16'(groups * RAW10_GROUP_BYTES), corrupt);
        for (int g = 0; g < groups; g++) begin
            for (int k = 0; k < PIXELS_PER_GROUP; k++) begin
                r = next_random();
                px[k] = r[9:0];
                low_bits[2*k +: 2] = px[k][1:0];
            end
            for (int k = 0; k < PIXELS_PER_GROUP; k++) send_byte(px[k][9:2], 1'b0);
            send_byte(low_bits, 1'b0);
            if (!corrupt && model_count < FB_WORDS) begin
                model_mem[model_count] = {px[3][9:2], px[2][9:2], px[1][9:2], px[0][9:2]};
                model_count++;
            end
        end
        send_crc();
        if (corrupt) expected_ecc_errors++;
    endtask

    task automatic send_foreign();
        logic [31:0] r;
        logic [5:0]  dt;
        r  = next_random();
        dt = {1'b1, r[4:0]};
        if (dt == DT_RAW10) dt = 6'h12;
        send_header(dt, 16'(r[11:8]), 1'b0);
        for (int i = 0; i < int'(r[11:8]); i++) send_byte(8'(next_random()), 1'b0);
        send_crc();
    endtask

    task automatic check_buffer();
        reads_on = 1'b0;
        drive_cycle(1'b0, 8'h00, 1'b0);  // drains the background read
        for (int a = 0; a < model_count; a++) begin
            @(posedge byte_clk_hs);
            #2;
            camera_ram_read_enable_i  = 1'b1;
            camera_ram_read_address_i = FB_ADDR_W'(a);
            @(posedge byte_clk_hs);
            #2;
            camera_ram_read_enable_i = 1'b0;
            assert (camera_ram_read_data_o == model_mem[a])
                else report_error($sformatf("word %0d is %h, expected %h",
                                            a, camera_ram_read_data_o, model_mem[a]));
        end
        reads_on = 1'b1;
    endtask

    task automatic run_frame(input int lines, input int max_groups, input bit fixed,
                             input bit mixed);
        int groups;
        bit corrupt;
        send_header(DT_FRAME_START, 16'h0000, 1'b0);
        model_count = 0;
        for (int l = 0; l < lines; l++) begin
            if (mixed && (l == 2 || next_random() % 3 == 0)) send_foreign();
            groups  = fixed ? max_groups : 1 + int'(next_random() % max_groups);
            corrupt = mixed && (l == 1 || next_random() % 5 == 0);  // at least one bad header
            send_line(groups, corrupt);
        end
        assert (frame_active_o) else report_error("frame_active_o low inside a frame");
        send_header(DT_FRAME_END, 16'h0000, 1'b0);
        expected_frames++;
        while (frame_count_o != expected_frames) drive_cycle(1'b0, 8'h00, 1'b0);
        assert (!frame_active_o) else report_error("frame_active_o high after frame end");
        assert (ecc_error_count_o == expected_ecc_errors)
            else report_error($sformatf("ecc_error_count_o is %0d, expected %0d",
                                        ecc_error_count_o, expected_ecc_errors));
        check_buffer();
    endtask

    initial begin
        cycles = 0;
        forever begin
            @(posedge byte_clk_hs);
            cycles++;
            if (cycles > 8 * bytes_sent + 2000) begin
                $display("timeout: the DUT did not finish the frames in time");
                $display("Testbench failed");
                $fatal(1);
            end
        end
    end

    initial begin
        byte_clk_hs               = 1'b0;
        reset_n_clock_96MHz       = 1'b0;
        byte_valid_i              = 1'b0;
        byte_i                    = 8'h00;
        sot_i                     = 1'b0;
        camera_ram_read_enable_i  = 1'b0;
        camera_ram_read_address_i = '0;
        model_count               = 0;
        expected_frames           = 8'd0;
        expected_ecc_errors       = 8'd0;
        bytes_sent                = 0;
        read_pending              = 1'b0;
        reads_on                  = 1'b1;
        repeat (4) @(posedge byte_clk_hs);
        #2;
        reset_n_clock_96MHz = 1'b1;
        run_frame(12, 8, 1'b0, 1'b1);   // foreign packets and bad headers mixed in
        run_frame(6, 6, 1'b0, 1'b0);    // restarts at address 0
        run_frame(7, 40, 1'b1, 1'b0);   // 280 groups, overflow
        run_frame(4, 5, 1'b0, 1'b1);
        $display("Testbench passed");
        $finish;
    end

endmodule

// File: flist.f
logic/camera_pkg.sv
logic/camera_if.sv
logic/csi2_packet_decode.sv
logic/raw10_unpack.sv
logic/frame_buffer.sv
logic/camera.sv
tests/camera_sva.sv
tests/camera_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build and run the camera testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module camera_tb -f flist.f -o camera_sim \
    || { echo "build failed"; exit 1; }

out="$(./obj_dir/camera_sim 2>&1)"
echo "$out"

grep -q "Testbench passed" <<< "$out" && exit 0 || exit 1
